// ==== common/hps_proto_pkg.sv ====
//////////////////////////////////////////////////
// host protocol definitions
// word widths, command opcodes and the framing
// space of the host-to-core command port
//////////////////////////////////////////////////

package hps_proto_pkg;

	// host bus word and word counter
	localparam int host_word_w = 16;
	localparam int word_cnt_w = 4;

	// commands framed by io_enable
	typedef enum logic [host_word_w-1:0] {
		cfg_wr        = 16'h0001,
		joy0_wr       = 16'h0002,
		joy1_wr       = 16'h0003,
		status_wr     = 16'h001E,
		status_req_rd = 16'h0029,
		menumask_rd   = 16'h002E
	} uio_cmd_e;

	// commands framed by fp_enable
	typedef enum logic [host_word_w-1:0] {
		file_tx     = 16'h0053,
		file_tx_dat = 16'h0054,
		file_index  = 16'h0055,
		file_info   = 16'h0056
	} fio_cmd_e;

	// which enable framed the word
	typedef enum logic {
		space_uio,
		space_fio
	} cmd_space_e;

	// upper nibble of the first status request reply
	localparam logic [3:0] status_req_tag = 4'hA;

endpackage

// ==== common/core_io_pkg.sv ====
//////////////////////////////////////////////////
// core side definitions
// widths of the settings and download signals
// that the command port drives into the core
//////////////////////////////////////////////////

package core_io_pkg;

	// digital joystick, 32 buttons
	localparam int joy_w = 32;

	// menu status word and its change counter
	localparam int status_w = 64;
	localparam int status_flag_w = 4;

	// framework config word
	localparam int cfg_w = 16;

	// download port
	localparam int dl_addr_w = 27;
	localparam int dl_byte_w = 8;
	localparam int file_ext_w = 32;

endpackage

// ==== common/host_word_if.sv ====
//////////////////////////////////////////////////
// host word interface
// one framed host word from the framing stage
// to the command stages
//////////////////////////////////////////////////

`timescale 1ns/1ps

interface host_word_if
	import hps_proto_pkg::*;
;
	logic                   valid;
	cmd_space_e             space;
	logic [host_word_w-1:0] cmd;
	logic [word_cnt_w-1:0]  idx;
	logic [host_word_w-1:0] data;
	logic                   frame_end;

	modport src (output valid, space, cmd, idx, data, frame_end);
	modport dst (input valid, space, cmd, idx, data, frame_end);

endinterface

// ==== rtl/host_frame.sv ====
//////////////////////////////////////////////////
// host framing stage
// counts strobed words, latches the command and
// forwards every word with its index
//////////////////////////////////////////////////

`timescale 1ns/1ps

module host_frame
	import hps_proto_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   rst,
	input  logic                   io_enable,
	input  logic                   fp_enable,
	input  logic                   io_strobe,
	input  logic [host_word_w-1:0] io_din,
	host_word_if.src               word
);

	logic                   en_any;
	logic                   en_q;
	logic [word_cnt_w-1:0]  word_cnt;
	logic [host_word_w-1:0] cmd_q;
	logic                   take;

	assign en_any = io_enable | fp_enable;
	assign take = en_any & io_strobe;

	// frame control
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			en_q <= 1'b0;
			word_cnt <= '0;
			word.valid <= 1'b0;
			word.frame_end <= 1'b0;
		end else begin
			en_q <= en_any;
			word.frame_end <= en_q & ~en_any;
			word.valid <= take;
			if (!en_any) begin
				word_cnt <= '0;
			end else if (io_strobe && !(&word_cnt)) begin
				// saturate so long frames keep the last index
				word_cnt <= word_cnt + 1'b1;
			end
		end
	end

	// word payload, the first word of a frame is the command
	always_ff @(posedge clk_sys) begin
		if (take) begin
			word.idx <= word_cnt;
			word.data <= io_din;
			word.space <= io_enable ? space_uio : space_fio;
			if (word_cnt == '0) begin
				cmd_q <= io_din;
				word.cmd <= io_din;
			end else begin
				word.cmd <= cmd_q;
			end
		end
	end

endmodule

// ==== rtl/core_settings.sv ====
//////////////////////////////////////////////////
// core settings stage
// config, joysticks and status writes, plus the
// status request and menu mask readback
//////////////////////////////////////////////////

`timescale 1ns/1ps

module core_settings
	import hps_proto_pkg::*, core_io_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   rst,
	host_word_if.dst               word,
	input  logic [status_w-1:0]    status_in,
	input  logic                   status_set,
	input  logic [host_word_w-1:0] status_menumask,
	output logic [cfg_w-1:0]       cfg,
	output logic [joy_w-1:0]       joystick_0,
	output logic [joy_w-1:0]       joystick_1,
	output logic [status_w-1:0]    status,
	output logic [host_word_w-1:0] reply
);

	logic                     uio_data;
	logic                     quarter_hit;
	logic [1:0]               quarter;
	logic                     status_set_q;
	logic                     status_set_rise;
	logic [status_flag_w-1:0] stflg;
	logic [status_w-1:0]      status_req;

	assign uio_data = word.valid && (word.space == space_uio) && (word.idx != '0);

	// 64-bit words travel as four 16-bit quarters at idx 1 to 4
	assign quarter_hit = word.idx inside {[1:4]};
	assign quarter = word.idx[1:0] - 2'd1;

	assign status_set_rise = status_set & ~status_set_q;

	//////////////////////////////////////////////////
	// settings written by the host
	//////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cfg <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status <= '0;
			status_set_q <= 1'b0;
			stflg <= '0;
		end else begin
			status_set_q <= status_set;
			// each status change request bumps the counter
			if (status_set_rise) begin
				stflg <= stflg + 1'b1;
			end
			if (uio_data) begin
				case (word.cmd)
					cfg_wr: cfg <= word.data;
					joy0_wr: begin
						if (word.idx == 1)
							joystick_0[host_word_w-1:0] <= word.data;
						else if (word.idx == 2)
							joystick_0[joy_w-1:host_word_w] <= word.data;
					end
					joy1_wr: begin
						if (word.idx == 1)
							joystick_1[host_word_w-1:0] <= word.data;
						else if (word.idx == 2)
							joystick_1[joy_w-1:host_word_w] <= word.data;
					end
					status_wr: begin
						if (quarter_hit)
							status[{quarter, 4'b0000} +: host_word_w] <= word.data;
					end
					default: ;
				endcase
			end
		end
	end

	// status value the core asks the host to take over
	always_ff @(posedge clk_sys) begin
		if (status_set_rise) begin
			status_req <= status_in;
		end
	end

	//////////////////////////////////////////////////
	// readback toward the host
	//////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			reply <= '0;
		end else if (word.frame_end) begin
			reply <= '0;
		end else if (word.valid) begin
			reply <= '0;
			if (word.space == space_uio) begin
				case (word.cmd)
					status_req_rd: begin
						// tag and counter answer the command word itself
						if (word.idx == 0)
							reply <= {{(host_word_w - 4 - status_flag_w){1'b0}},
								status_req_tag, stflg};
						else if (quarter_hit)
							reply <= status_req[{quarter, 4'b0000} +: host_word_w];
					end
					menumask_rd: begin
						if (word.idx == 1)
							reply <= status_menumask;
					end
					default: ;
				endcase
			end
		end
	end

endmodule

// ==== file_io/file_download.sv ====
//////////////////////////////////////////////////
// file download stage
// file index, extension, download start and stop
// and byte writes into the core
//////////////////////////////////////////////////

`timescale 1ns/1ps

module file_download
	import hps_proto_pkg::*, core_io_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   rst,
	host_word_if.dst               word,
	output logic                   ioctl_download,
	output logic [host_word_w-1:0] ioctl_index,
	output logic [file_ext_w-1:0]  ioctl_file_ext,
	output logic                   ioctl_wr,
	output logic [dl_addr_w-1:0]   ioctl_addr,
	output logic [dl_byte_w-1:0]   ioctl_dout
);

	logic                 fio_data;
	logic                 byte_wr;
	logic [dl_addr_w-1:0] addr;

	assign fio_data = word.valid && (word.space == space_fio) && (word.idx != '0);

	// bytes outside an active download are dropped
	assign byte_wr = fio_data && (word.cmd == file_tx_dat) && ioctl_download;

	// download state and write strobe
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			ioctl_download <= 1'b0;
			ioctl_wr <= 1'b0;
		end else begin
			ioctl_wr <= byte_wr;
			if (fio_data && (word.cmd == file_tx) && (word.idx == 1)) begin
				ioctl_download <= (word.data[dl_byte_w-1:0] != '0);
			end
		end
	end

	//////////////////////////////////////////////////
	// file info and write address
	//////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (byte_wr) begin
			ioctl_addr <= addr;
			ioctl_dout <= word.data[dl_byte_w-1:0];
			addr <= addr + 1'b1;
		end else if (fio_data) begin
			case (word.cmd)
				file_index: ioctl_index <= word.data;
				file_info: begin
					// extension arrives high half first
					if (word.idx == 1)
						ioctl_file_ext[file_ext_w-1:host_word_w] <= word.data;
					else if (word.idx == 2)
						ioctl_file_ext[host_word_w-1:0] <= word.data;
				end
				file_tx: begin
					if (word.idx == 1) begin
						if (word.data[dl_byte_w-1:0] != '0)
							addr <= '0;
						else if (ioctl_download)
							// stop leaves the end address on the port
							ioctl_addr <= addr;
					end else if (word.idx == 2) begin
						addr[host_word_w-1:0] <= word.data;
						ioctl_addr[host_word_w-1:0] <= word.data;
					end else if (word.idx == 3) begin
						addr[dl_addr_w-1:host_word_w] <=
							word.data[dl_addr_w-host_word_w-1:0];
						ioctl_addr[dl_addr_w-1:host_word_w] <=
							word.data[dl_addr_w-host_word_w-1:0];
					end
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== rtl/hps_io.sv ====
//////////////////////////////////////////////////
// host command port top
// framing, core settings and file download
// behind a strobed 16-bit host bus
//////////////////////////////////////////////////

`timescale 1ns/1ps

module hps_io
	import hps_proto_pkg::*, core_io_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   rst,
	// host bus
	input  logic                   io_enable,
	input  logic                   fp_enable,
	input  logic                   io_strobe,
	input  logic [host_word_w-1:0] io_din,
	output logic [host_word_w-1:0] io_dout,
	output logic                   hps_wait,
	// core settings
	output logic [cfg_w-1:0]       cfg,
	output logic [1:0]             buttons,
	output logic                   forced_scandoubler,
	output logic                   direct_video,
	output logic [joy_w-1:0]       joystick_0,
	output logic [joy_w-1:0]       joystick_1,
	output logic [status_w-1:0]    status,
	input  logic [status_w-1:0]    status_in,
	input  logic                   status_set,
	input  logic [host_word_w-1:0] status_menumask,
	// file download
	output logic                   ioctl_download,
	output logic [host_word_w-1:0] ioctl_index,
	output logic [file_ext_w-1:0]  ioctl_file_ext,
	output logic                   ioctl_wr,
	output logic [dl_addr_w-1:0]   ioctl_addr,
	output logic [dl_byte_w-1:0]   ioctl_dout,
	input  logic                   ioctl_wait
);

	host_word_if word ();

	// the core stalls the host directly, nothing is buffered here
	assign hps_wait = ioctl_wait;

	// config bits decoded for the core
	assign buttons = cfg[1:0];
	assign forced_scandoubler = cfg[4];
	assign direct_video = cfg[10];

	host_frame u_frame (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.io_enable (io_enable),
		.fp_enable (fp_enable),
		.io_strobe (io_strobe),
		.io_din    (io_din),
		.word      (word.src)
	);

	// only the settings stage answers, the file port has no readback
	core_settings u_settings (
		.clk_sys         (clk_sys),
		.rst             (rst),
		.word            (word.dst),
		.status_in       (status_in),
		.status_set      (status_set),
		.status_menumask (status_menumask),
		.cfg             (cfg),
		.joystick_0      (joystick_0),
		.joystick_1      (joystick_1),
		.status          (status),
		.reply           (io_dout)
	);

	file_download u_download (
		.clk_sys        (clk_sys),
		.rst            (rst),
		.word           (word.dst),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_file_ext (ioctl_file_ext),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout)
	);

endmodule

// ==== tests/hps_io_tb.sv ====
//////////////////////////////////////////////////
// host command port testbench
// drives framed host words into the port and
// checks settings, readback and download bytes
//////////////////////////////////////////////////

`timescale 1ns/1ps

module hps_io_tb
	import hps_proto_pkg::*, core_io_pkg::*;
();

	localparam int clk_period = 100;
	localparam int n_frames = 29;

	logic                   clk_sys = 1'b0;
	logic                   rst;
	logic                   io_enable, fp_enable, io_strobe;
	logic [host_word_w-1:0] io_din, io_dout, status_menumask;
	logic                   hps_wait, ioctl_wait;
	logic [cfg_w-1:0]       cfg;
	logic [1:0]             buttons;
	logic                   forced_scandoubler, direct_video;
	logic [joy_w-1:0]       joystick_0, joystick_1;
	logic [status_w-1:0]    status, status_in;
	logic                   status_set;
	logic                   ioctl_download, ioctl_wr;
	logic [host_word_w-1:0] ioctl_index;
	logic [file_ext_w-1:0]  ioctl_file_ext;
	logic [dl_addr_w-1:0]   ioctl_addr;
	logic [dl_byte_w-1:0]   ioctl_dout;

	// reference model state
	logic [cfg_w-1:0]         m_cfg;
	logic [joy_w-1:0]         m_joy0, m_joy1;
	logic [status_w-1:0]      m_status, m_req;
	logic [status_flag_w-1:0] m_flg;
	logic [dl_addr_w-1:0]     exp_addr;
	logic [dl_byte_w-1:0]     exp_byte;
	logic [dl_byte_w-1:0]     byte_q[$];
	logic [host_word_w-1:0]   frame_q[$];
	logic [host_word_w-1:0]   reply_q[$];
	logic                     bp_on;

	hps_io UUT (.*);

	always #(clk_period / 2) clk_sys = ~clk_sys;

	task automatic compare(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			$display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
			$display("Test failed");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic logic [63:0] ref_field(input logic [63:0] old, input int pos,
		input logic [15:0] d);
		logic [63:0] r;
		r = old;
		r[pos*16 +: 16] = d;
		return r;
	endfunction

	// expected io_dout for a word of a settings frame
	function automatic logic [15:0] ref_reply(input logic [15:0] cmd, input int idx);
		logic [15:0] r;
		r = 16'h0000;
		if (cmd == status_req_rd && idx == 0)
			r = {8'h00, status_req_tag, m_flg};
		else if (cmd == status_req_rd && idx >= 1 && idx <= 4)
			r = m_req[(idx-1)*16 +: 16];
		else if (cmd == menumask_rd && idx == 1)
			r = status_menumask;
		return r;
	endfunction

	// sends one frame from frame_q and collects each reply 2 cycles after its strobe
	task automatic send_frame(input logic fio);
		logic [15:0] w;
		int          stall;
		reply_q.delete();
		if (fio)
			fp_enable = 1'b1;
		else
			io_enable = 1'b1;
		@(negedge clk_sys);
		while (frame_q.size() > 0) begin
			w = frame_q.pop_front();
			if (bp_on && ($urandom_range(3) == 0)) begin
				stall = $urandom_range(4, 1);
				ioctl_wait = 1'b1;
				repeat (stall) begin
					@(negedge clk_sys);
					compare(64'(hps_wait), 64'd1, "hps_wait");
				end
				ioctl_wait = 1'b0;
				@(negedge clk_sys);
				compare(64'(hps_wait), 64'd0, "hps_wait");
			end
			while (hps_wait)
				@(negedge clk_sys);
			io_din = w;
			io_strobe = 1'b1;
			@(negedge clk_sys);
			io_strobe = 1'b0;
			@(negedge clk_sys);
			reply_q.push_back(io_dout);
			// file frames never answer
			if (fio)
				compare(64'(io_dout), 64'd0, "io_dout in file frame");
			repeat (3) @(negedge clk_sys);
		end
		io_enable = 1'b0;
		fp_enable = 1'b0;
		repeat (3) @(negedge clk_sys);
	endtask

	task automatic run_download(input int n_chunks);
		logic [15:0] lo, hi, d, idx_v;
		logic [31:0] ext;
		idx_v = 16'($urandom);
		ext = $urandom;
		frame_q.push_back(file_index);
		frame_q.push_back(idx_v);
		send_frame(1'b1);
		frame_q.push_back(file_info);
		frame_q.push_back(ext[31:16]);
		frame_q.push_back(ext[15:0]);
		send_frame(1'b1);
		compare(64'(ioctl_index), 64'(idx_v), "ioctl_index");
		compare(64'(ioctl_file_ext), 64'(ext), "ioctl_file_ext");
		lo = 16'($urandom);
		hi = 16'($urandom);
		exp_addr = {hi[10:0], lo};
		frame_q.push_back(file_tx);
		frame_q.push_back({8'($urandom), 8'($urandom_range(255, 1))});
		frame_q.push_back(lo);
		frame_q.push_back(hi);
		send_frame(1'b1);
		compare(64'(ioctl_download), 64'd1, "ioctl_download after start");
		for (int c = 0; c < n_chunks; c++) begin
			frame_q.push_back(file_tx_dat);
			for (int b = 0; b < 5; b++) begin
				d = 16'($urandom);
				byte_q.push_back(d[7:0]);
				frame_q.push_back(d);
			end
			send_frame(1'b1);
		end
		frame_q.push_back(file_tx);
		frame_q.push_back({8'($urandom), 8'h00});
		send_frame(1'b1);
		compare(64'(ioctl_download), 64'd0, "ioctl_download after stop");
		compare(64'(byte_q.size()), 64'd0, "bytes still pending");
	endtask

	////////////////////////////////////////////////
	// download byte checker
	////////////////////////////////////////////////
	always @(negedge clk_sys) begin
		if (!rst && ioctl_wr) begin
			if (byte_q.size() == 0) begin
				$display("ioctl_wr pulse at %0t with no byte sent by the host", $time);
				$display("Test failed");
				$fatal(1, "unexpected write");
			end else begin
				exp_byte = byte_q.pop_front();
				compare(64'(ioctl_addr), 64'(exp_addr), "ioctl_addr");
				compare(64'(ioctl_dout), 64'(exp_byte), "ioctl_dout");
				exp_addr = exp_addr + 1'b1;
			end
		end
	end

	// watchdog
	initial begin
		#(n_frames * 60 * clk_period);
		$display("timeout: the run did not finish within %0d cycles", n_frames * 60);
		$display("Test failed");
		$fatal(1, "watchdog expired");
	end

	////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////
	initial begin
		logic [15:0] d, lo, hi;
		void'($urandom(32'h36a37724));
		rst = 1'b1;
		io_enable = 1'b0;
		fp_enable = 1'b0;
		io_strobe = 1'b0;
		io_din = '0;
		status_in = '0;
		status_set = 1'b0;
		status_menumask = 16'($urandom);
		ioctl_wait = 1'b0;
		bp_on = 1'b0;
		m_cfg = '0;
		m_joy0 = '0;
		m_joy1 = '0;
		m_status = '0;
		m_req = '0;
		m_flg = '0;
		exp_addr = '0;
		repeat (8) @(posedge clk_sys);
		@(negedge clk_sys);
		rst = 1'b0;
		@(negedge clk_sys);

		// config and joysticks
		for (int i = 0; i < 4; i++) begin
			d = 16'($urandom);
			frame_q.push_back(cfg_wr);
			frame_q.push_back(d);
			send_frame(1'b0);
			m_cfg = d;
			lo = 16'($urandom);
			hi = 16'($urandom);
			frame_q.push_back(joy0_wr);
			frame_q.push_back(lo);
			frame_q.push_back(hi);
			send_frame(1'b0);
			m_joy0 = {hi, lo};
			lo = 16'($urandom);
			hi = 16'($urandom);
			frame_q.push_back(joy1_wr);
			frame_q.push_back(lo);
			frame_q.push_back(hi);
			send_frame(1'b0);
			m_joy1 = {hi, lo};
			compare(64'(cfg), 64'(m_cfg), "cfg");
			compare(64'(buttons), 64'(m_cfg[1:0]), "buttons");
			compare(64'(forced_scandoubler), 64'(m_cfg[4]), "forced_scandoubler");
			compare(64'(direct_video), 64'(m_cfg[10]), "direct_video");
			compare(64'(joystick_0), 64'(m_joy0), "joystick_0");
			compare(64'(joystick_1), 64'(m_joy1), "joystick_1");
		end

		// status word written low quarter first
		frame_q.push_back(status_wr);
		for (int q = 0; q < 4; q++) begin
			d = 16'($urandom);
			frame_q.push_back(d);
			m_status = ref_field(m_status, q, d);
		end
		send_frame(1'b0);
		compare(status, m_status, "status");

		// status change requests and readback
		for (int k = 0; k < 3; k++) begin
			status_in = {$urandom, $urandom};
			status_set = 1'b1;
			m_flg = m_flg + 1'b1;
			m_req = status_in;
			repeat (2) @(negedge clk_sys);
			status_set = 1'b0;
			repeat (2) @(negedge clk_sys);
		end
		frame_q.push_back(status_req_rd);
		for (int q = 0; q < 4; q++)
			frame_q.push_back(16'h0000);
		send_frame(1'b0);
		for (int j = 0; j < 5; j++)
			compare(64'(reply_q[j]), 64'(ref_reply(status_req_rd, j)), "status_req_rd reply");
		frame_q.push_back(menumask_rd);
		frame_q.push_back(16'h0000);
		send_frame(1'b0);
		for (int j = 0; j < 2; j++)
			compare(64'(reply_q[j]), 64'(ref_reply(menumask_rd, j)), "menumask_rd reply");

		// a download, stray bytes outside it and a download under back-pressure
		run_download(2);
		frame_q.push_back(file_tx_dat);
		for (int b = 0; b < 4; b++)
			frame_q.push_back(16'($urandom));
		send_frame(1'b1);
		bp_on = 1'b1;
		run_download(3);
		bp_on = 1'b0;

		$display("Test passed");
		$finish;
	end

endmodule

// ==== hps_io.f ====
common/hps_proto_pkg.sv
common/core_io_pkg.sv
common/host_word_if.sv
rtl/host_frame.sv
rtl/core_settings.sv
file_io/file_download.sv
rtl/hps_io.sv
tests/hps_io_tb.sv

// ==== Makefile ====
# Verilator build and run for the host command port

VERILATOR ?= verilator
TOP       ?= hps_io_tb
FILE_LIST ?= hps_io.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Test passed

SRCS    := $(shell grep -v '^+' $(FILE_LIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
